// File: source/asic_pkg.sv
// Shared definitions for the SAM Coupe I/O and paging block.
// Holds the bus and sample vector types, the I/O port numbers
// and the MIDI frame timing. Modules take it by wildcard import.

package asic_pkg;

	// ========================================
	// Vector types
	// ========================================

	// Byte on the port bus and in the ASIC registers
	typedef logic [7:0] data_t;

	// Full Z80 address
	typedef logic [15:0] cpu_addr_t;

	// I/O port number, low byte of the address
	typedef logic [7:0] port_t;

	// RAM page, top bit selects external RAM
	typedef logic [8:0] page_t;

	// Unsigned audio sample
	typedef logic [15:0] sample_t;

	// ========================================
	// Port numbers
	// ========================================

	localparam port_t PORT_EXT_C      = 8'd128;
	localparam port_t PORT_EXT_D      = 8'd129;
	localparam port_t PORT_LPT_DATA   = 8'd232;
	localparam port_t PORT_LPT_STROBE = 8'd233;
	localparam port_t PORT_STATUS     = 8'd249;
	localparam port_t PORT_LMPR       = 8'd250;
	localparam port_t PORT_HMPR       = 8'd251;
	localparam port_t PORT_MIDI       = 8'd253;
	localparam port_t PORT_BORDER     = 8'd254;

	// ========================================
	// MIDI timing, in microsecond ticks
	// ========================================

	// One byte at 31250 baud, 10 bits
	localparam int MIDI_FRAME_TICKS = 320;
	// Remaining count where the interrupt is raised
	localparam int MIDI_INT_TICK    = 15;

endpackage

// File: source/asic_port_decoder.sv
// Port bus front end of the ASIC.
// Finds the rising edge of io_wr and turns the port number into a
// single-cycle write strobe for the addressed register. Also builds
// the combinational read byte for LMPR, HMPR and the status port.

`timescale 1ns/1ps

module asic_port_decoder
	import asic_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  cpu_addr_t cpu_addr,
	input  logic      io_wr,
	input  logic      io_rd,
	input  data_t     lmpr,
	input  data_t     hmpr,
	input  logic      midi_int,
	output logic      lmpr_we,
	output logic      hmpr_we,
	output logic      ext_c_we,
	output logic      ext_d_we,
	output logic      midi_we,
	output logic      border_we,
	output logic      lpt_data_we,
	output logic      lpt_strobe_we,
	output data_t     rd_data
);

	port_t port;
	logic  wr_prev;
	logic  wr_edge;

	// Only the low address byte selects the port
	assign port = cpu_addr[7:0];

	// ========================================
	// Write edge detection
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_prev <= 1'b0;
		end else begin
			wr_prev <= io_wr;
		end
	end

	// High for the first cycle of a write only
	assign wr_edge = io_wr & ~wr_prev;

	// Port numbers are distinct, so one strobe at most
	assign ext_c_we      = wr_edge & (port == PORT_EXT_C);
	assign ext_d_we      = wr_edge & (port == PORT_EXT_D);
	assign lpt_data_we   = wr_edge & (port == PORT_LPT_DATA);
	assign lpt_strobe_we = wr_edge & (port == PORT_LPT_STROBE);
	assign lmpr_we       = wr_edge & (port == PORT_LMPR);
	assign hmpr_we       = wr_edge & (port == PORT_HMPR);
	assign midi_we       = wr_edge & (port == PORT_MIDI);
	assign border_we     = wr_edge & (port == PORT_BORDER);

	// ========================================
	// Read multiplexer
	// ========================================

	always_comb begin
		rd_data = 8'hFF;
		if (io_rd) begin
			case (port)
				// Keyboard, line and frame bits idle high
				PORT_STATUS: rd_data = {3'b111, ~midi_int, 4'b1111};
				PORT_LMPR:   rd_data = lmpr;
				PORT_HMPR:   rd_data = hmpr;
				default:     rd_data = 8'hFF;
			endcase
		end
	end

endmodule

// File: source/memory_pager.sv
// Memory paging registers and page arithmetic.
// Holds LMPR, HMPR and the two external RAM page ports, and maps
// the top two CPU address bits to a 9-bit RAM page, a ROM select
// and a write protect flag. The mapping is purely combinational.

`timescale 1ns/1ps

module memory_pager
	import asic_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  cpu_addr_t cpu_addr,
	input  data_t     wr_data,
	input  logic      lmpr_we,
	input  logic      hmpr_we,
	input  logic      ext_c_we,
	input  logic      ext_d_we,
	output data_t     lmpr,
	output data_t     hmpr,
	output page_t     ram_page,
	output logic      rom_sel,
	output logic      ram_wp
);

	data_t      ext_c;
	data_t      ext_d;
	logic [1:0] quarter;
	logic [4:0] page_ab;
	logic [4:0] page_cd;
	logic       ext_sel;
	logic       rom0_sel;
	logic       rom1_sel;

	// ========================================
	// Page registers
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			lmpr  <= '0;
			hmpr  <= '0;
			ext_c <= '0;
			ext_d <= '0;
		end else begin
			if (lmpr_we)  lmpr  <= wr_data;
			if (hmpr_we)  hmpr  <= wr_data;
			if (ext_c_we) ext_c <= wr_data;
			if (ext_d_we) ext_d <= wr_data;
		end
	end

	// ========================================
	// Address mapping
	// ========================================

	assign quarter = cpu_addr[15:14];
	assign page_ab = lmpr[4:0];
	assign page_cd = hmpr[4:0];

	// External RAM covers the upper half when HMPR bit 7 is set
	assign ext_sel = hmpr[7] & cpu_addr[15];

	always_comb begin
		if (ext_sel) begin
			ram_page = quarter[0] ? {1'b1, ext_d} : {1'b1, ext_c};
		end else begin
			// Page plus one wraps within the 32 internal pages
			case (quarter)
				2'd0:    ram_page = {4'b0000, page_ab};
				2'd1:    ram_page = {4'b0000, 5'(page_ab + 5'd1)};
				2'd2:    ram_page = {4'b0000, page_cd};
				default: ram_page = {4'b0000, 5'(page_cd + 5'd1)};
			endcase
		end
	end

	// ROM0 is active low in LMPR, ROM1 active high
	assign rom0_sel = ~lmpr[5] & (quarter == 2'd0);
	assign rom1_sel =  lmpr[6] & (quarter == 2'd3);
	assign rom_sel  = (rom0_sel | rom1_sel) & ~ext_sel;

	// Write protect only guards the bottom quarter
	assign ram_wp = lmpr[7] & (quarter == 2'd0);

endmodule

// File: source/midi_transmitter.sv
// MIDI transmit timing model.
// A divider makes a one-cycle tick every TICK_DIV clocks. A write
// to the MIDI port marks a byte pending, and the next idle tick
// starts a frame of MIDI_FRAME_TICKS ticks with midi_tx high.
// midi_int rises near the end of the frame, both drop when it ends.

`timescale 1ns/1ps

module midi_transmitter
	import asic_pkg::*;
#(
	parameter int TICK_DIV = 96
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic midi_we,
	output logic midi_tx,
	output logic midi_int
);

	localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	logic [DIV_W-1:0] div_cnt;
	logic             tick;
	logic [8:0]       tx_time;
	logic             pending;

	// ========================================
	// Microsecond tick
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div_cnt <= '0;
			tick    <= 1'b0;
		end else begin
			tick <= (div_cnt == DIV_W'(TICK_DIV - 1));
			if (div_cnt == DIV_W'(TICK_DIV - 1)) begin
				div_cnt <= '0;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// ========================================
	// Frame timer
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			tx_time  <= '0;
			pending  <= 1'b0;
			midi_tx  <= 1'b0;
			midi_int <= 1'b0;
		end else begin
			if (tick) begin
				if (tx_time != '0) begin
					tx_time <= tx_time - 1'b1;
					if (tx_time == 9'(MIDI_INT_TICK)) midi_int <= 1'b1;
				end else begin
					midi_tx  <= 1'b0;
					midi_int <= 1'b0;
					if (pending) begin
						midi_tx <= 1'b1;
						tx_time <= 9'(MIDI_FRAME_TICKS - 1);
						pending <= 1'b0;
					end
				end
			end
			// New write wins over the tick that consumes the flag
			if (midi_we) pending <= 1'b1;
		end
	end

endmodule

// File: source/dac_mixer.sv
// Parallel port stereo DAC and audio mixer.
// Port 232 latches a sample byte, port 233 bit 0 edges copy it to
// the left (rising) or right (falling) channel. The border beeper
// bit is added on top and both channels come out as 16-bit samples.

`timescale 1ns/1ps

module dac_mixer
	import asic_pkg::*;
(
	input  logic    clk_sys,
	input  logic    reset,
	input  data_t   wr_data,
	input  logic    border_we,
	input  logic    lpt_data_we,
	input  logic    lpt_strobe_we,
	output sample_t audio_l,
	output sample_t audio_r
);

	logic  beeper;
	data_t lpt_data;
	logic  strobe_prev;
	data_t vox_l;
	data_t vox_r;

	// Byte doubled to full scale plus beeper, top 16 of 19 bits
	function automatic sample_t mix(input data_t vox, input logic beep);
		logic [18:0] sum;
		sum = {1'b0, vox, vox, 2'b00} + {1'b0, beep, 17'd0};
		return sum[18:3];
	endfunction

	// ========================================
	// Port registers
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			beeper      <= 1'b0;
			lpt_data    <= '0;
			strobe_prev <= 1'b0;
			vox_l       <= '0;
			vox_r       <= '0;
		end else begin
			// Only the beeper bit of the border port matters here
			if (border_we)   beeper   <= wr_data[4];
			if (lpt_data_we) lpt_data <= wr_data;
			if (lpt_strobe_we) begin
				if (~strobe_prev & wr_data[0]) vox_l <= lpt_data;
				if (strobe_prev & ~wr_data[0]) vox_r <= lpt_data;
				strobe_prev <= wr_data[0];
			end
		end
	end

	assign audio_l = mix(vox_l, beeper);
	assign audio_r = mix(vox_r, beeper);

endmodule

// File: source/sam_asic_top.sv
// Top level of the SAM Coupe I/O and paging block.
// Connects the port decoder to the pager, the MIDI transmitter
// and the DAC mixer. TICK_DIV sets clk_sys cycles per microsecond.

`timescale 1ns/1ps

module sam_asic_top
	import asic_pkg::*;
#(
	parameter int TICK_DIV = 96
) (
	input  logic      clk_sys,
	input  logic      reset,
	input  cpu_addr_t cpu_addr,
	input  data_t     wr_data,
	input  logic      io_wr,
	input  logic      io_rd,
	output data_t     rd_data,
	output page_t     ram_page,
	output logic      rom_sel,
	output logic      ram_wp,
	output logic      midi_tx,
	output logic      midi_int,
	output sample_t   audio_l,
	output sample_t   audio_r
);

	// Write strobes from the decoder
	logic lmpr_we;
	logic hmpr_we;
	logic ext_c_we;
	logic ext_d_we;
	logic midi_we;
	logic border_we;
	logic lpt_data_we;
	logic lpt_strobe_we;

	// Readback of the page registers
	data_t lmpr;
	data_t hmpr;

	asic_port_decoder decoder_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cpu_addr      (cpu_addr),
		.io_wr         (io_wr),
		.io_rd         (io_rd),
		.lmpr          (lmpr),
		.hmpr          (hmpr),
		.midi_int      (midi_int),
		.lmpr_we       (lmpr_we),
		.hmpr_we       (hmpr_we),
		.ext_c_we      (ext_c_we),
		.ext_d_we      (ext_d_we),
		.midi_we       (midi_we),
		.border_we     (border_we),
		.lpt_data_we   (lpt_data_we),
		.lpt_strobe_we (lpt_strobe_we),
		.rd_data       (rd_data)
	);

	memory_pager pager_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu_addr (cpu_addr),
		.wr_data  (wr_data),
		.lmpr_we  (lmpr_we),
		.hmpr_we  (hmpr_we),
		.ext_c_we (ext_c_we),
		.ext_d_we (ext_d_we),
		.lmpr     (lmpr),
		.hmpr     (hmpr),
		.ram_page (ram_page),
		.rom_sel  (rom_sel),
		.ram_wp   (ram_wp)
	);

	midi_transmitter #(
		.TICK_DIV (TICK_DIV)
	) midi_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.midi_we  (midi_we),
		.midi_tx  (midi_tx),
		.midi_int (midi_int)
	);

	dac_mixer mixer_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.wr_data       (wr_data),
		.border_we     (border_we),
		.lpt_data_we   (lpt_data_we),
		.lpt_strobe_we (lpt_strobe_we),
		.audio_l       (audio_l),
		.audio_r       (audio_r)
	);

endmodule

// File: sim/sam_asic_checker.sv
// Bus protocol assertions for the port decoder.
// Bound into asic_port_decoder. Checks the write strobes and the
// idle value of the read bus on every rising clock edge.

`timescale 1ns/1ps

module sam_asic_checker
	import asic_pkg::*;
(
	input logic  clk_sys,
	input logic  reset,
	input logic  io_wr,
	input logic  io_rd,
	input data_t rd_data,
	input logic  lmpr_we,
	input logic  hmpr_we,
	input logic  ext_c_we,
	input logic  ext_d_we,
	input logic  midi_we,
	input logic  border_we,
	input logic  lpt_data_we,
	input logic  lpt_strobe_we
);

	logic [7:0] pulses;

	assign pulses = {lmpr_we, hmpr_we, ext_c_we, ext_d_we,
		midi_we, border_we, lpt_data_we, lpt_strobe_we};

	// One port per write edge
	single_pulse_a: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0(pulses))
		else $error("More than one port write strobe in one cycle");

	idle_read_a: assert property (@(posedge clk_sys) disable iff (reset)
		!io_rd |-> (rd_data == 8'hFF))
		else $error("rd_data is not 0xFF while io_rd is low");

	// A held io_wr must not write again
	held_write_a: assert property (@(posedge clk_sys) disable iff (reset)
		$past(io_wr) |-> (pulses == 8'h00))
		else $error("Write strobe fired while io_wr was already high");

endmodule

bind asic_port_decoder sam_asic_checker checker_i (
	.clk_sys       (clk_sys),
	.reset         (reset),
	.io_wr         (io_wr),
	.io_rd         (io_rd),
	.rd_data       (rd_data),
	.lmpr_we       (lmpr_we),
	.hmpr_we       (hmpr_we),
	.ext_c_we      (ext_c_we),
	.ext_d_we      (ext_d_we),
	.midi_we       (midi_we),
	.border_we     (border_we),
	.lpt_data_we   (lpt_data_we),
	.lpt_strobe_we (lpt_strobe_we)
);

// File: sim/sam_asic_tb.sv
// Testbench for the SAM Coupe I/O and paging block.
// Drives the port bus on the falling clock edge and keeps its own
// copies of the paging and mixer registers. A compare process checks
// paging and audio outputs on every rising edge against them.
// Directed sequences cover reset, paging, held writes, MIDI and DAC.

`timescale 1ns/1ps

module sam_asic_tb
	import asic_pkg::*;
();

	localparam int TICK_DIV = 8;

	logic      clk_sys;
	logic      reset;
	cpu_addr_t cpu_addr;
	data_t     wr_data;
	logic      io_wr;
	logic      io_rd;
	data_t     rd_data;
	page_t     ram_page;
	logic      rom_sel;
	logic      ram_wp;
	logic      midi_tx;
	logic      midi_int;
	sample_t   audio_l;
	sample_t   audio_r;

	// Model copies of the DUT registers
	data_t       m_lmpr;
	data_t       m_hmpr;
	data_t       m_ext_c;
	data_t       m_ext_d;
	logic        m_beeper;
	data_t       m_lpt;
	logic        m_strobe;
	data_t       m_vox_l;
	data_t       m_vox_r;
	logic        checking;
	logic [10:0] exp_map;

	sam_asic_top #(
		.TICK_DIV (TICK_DIV)
	) dut_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu_addr (cpu_addr),
		.wr_data  (wr_data),
		.io_wr    (io_wr),
		.io_rd    (io_rd),
		.rd_data  (rd_data),
		.ram_page (ram_page),
		.rom_sel  (rom_sel),
		.ram_wp   (ram_wp),
		.midi_tx  (midi_tx),
		.midi_int (midi_int),
		.audio_l  (audio_l),
		.audio_r  (audio_r)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// ========================================
	// Reference model
	// ========================================

	// Returns {ram_page, rom_sel, ram_wp}
	function automatic logic [10:0] expected_paging(input cpu_addr_t addr);
		logic [1:0] q;
		logic [4:0] base;
		page_t      page;
		logic       rom;
		logic       wp;
		q  = addr[15:14];
		wp = m_lmpr[7] && (q == 2'd0);
		if (m_hmpr[7] && addr[15]) begin
			page = (q == 2'd2) ? {1'b1, m_ext_c} : {1'b1, m_ext_d};
			rom  = 1'b0;
		end else begin
			base = (q < 2'd2) ? m_lmpr[4:0] : m_hmpr[4:0];
			if (q[0]) base = base + 5'd1;
			page = {4'd0, base};
			rom  = ((q == 2'd0) && !m_lmpr[5]) || ((q == 2'd3) && m_lmpr[6]);
		end
		return {page, rom, wp};
	endfunction

	// Doubled byte plus beeper at bit 17 as the top 16 of 19 bits
	function automatic sample_t mixed_sample(input data_t vox, input logic beep);
		logic [18:0] full;
		full = (19'(vox) << 10) + (19'(vox) << 2) + (19'(beep) << 17);
		return full[18:3];
	endfunction

	task automatic update_model(input port_t port, input data_t data);
		case (port)
			PORT_LMPR:      m_lmpr = data;
			PORT_HMPR:      m_hmpr = data;
			PORT_EXT_C:     m_ext_c = data;
			PORT_EXT_D:     m_ext_d = data;
			PORT_BORDER:    m_beeper = data[4];
			PORT_LPT_DATA:  m_lpt = data;
			PORT_LPT_STROBE: begin
				if (!m_strobe && data[0]) m_vox_l = m_lpt;
				if (m_strobe && !data[0]) m_vox_r = m_lpt;
				m_strobe = data[0];
			end
			default: ;
		endcase
	endtask

	// ========================================
	// Checks and bus tasks
	// ========================================

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			stop_with_failure($sformatf("MISMATCH at %0t: %s got 0x%0h expected 0x%0h",
				$time, name, actual, expected));
		end
	endtask

	// Bus tasks start and end on a falling edge
	task automatic write_port(input port_t port, input data_t data);
		cpu_addr = {8'h00, port};
		wr_data  = data;
		io_wr    = 1'b1;
		@(negedge clk_sys);
		update_model(port, data);
		io_wr = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic read_port(input port_t port, output data_t data);
		cpu_addr = {8'h00, port};
		io_rd    = 1'b1;
		@(negedge clk_sys);
		data  = rd_data;
		io_rd = 1'b0;
	endtask

	// One MIDI byte and optionally a second one during the frame
	task automatic run_midi(input logic second_write, output int int_rises);
		int    cycles;
		int    limit;
		logic  int_prev;
		data_t status;
		int_rises = 0;
		write_port(PORT_MIDI, 8'($urandom));
		// The write itself took two cycles
		cycles = 2;
		while (!midi_tx) begin
			if (cycles >= TICK_DIV + 2) begin
				stop_with_failure("Timeout: midi_tx did not rise after a MIDI write");
			end
			@(negedge clk_sys);
			cycles++;
		end
		if (second_write) write_port(PORT_MIDI, 8'($urandom));
		limit    = (second_write ? 2 : 1) * (MIDI_FRAME_TICKS + 1) * TICK_DIV;
		cycles   = 0;
		int_prev = midi_int;
		while (midi_tx) begin
			if (cycles >= limit) begin
				stop_with_failure("Timeout: midi_tx stayed high longer than the frame");
			end
			if (midi_int && !int_prev) begin
				int_rises++;
				// Bit 4 low, all other status bits idle high
				read_port(PORT_STATUS, status);
				check_value("status", 32'(status), 32'(8'hEF));
				cycles++;
			end
			int_prev = midi_int;
			@(negedge clk_sys);
			cycles++;
		end
		check_value("midi_int", 32'(midi_int), 32'(0));
	endtask

	// Compare process
	always @(posedge clk_sys) begin
		if (checking) begin
			exp_map = expected_paging(cpu_addr);
			check_value("ram_page", 32'(ram_page), 32'(exp_map[10:2]));
			check_value("rom_sel", 32'(rom_sel), 32'(exp_map[1]));
			check_value("ram_wp", 32'(ram_wp), 32'(exp_map[0]));
			check_value("audio_l", 32'(audio_l), 32'(mixed_sample(m_vox_l, m_beeper)));
			check_value("audio_r", 32'(audio_r), 32'(mixed_sample(m_vox_r, m_beeper)));
		end
	end

	// ========================================
	// Stimulus
	// ========================================

	initial begin
		data_t value;
		data_t first;
		data_t second;
		port_t port;
		int    rises;
		void'($urandom(39));
		cpu_addr = '0;
		wr_data  = '0;
		io_wr    = 1'b0;
		io_rd    = 1'b0;
		reset    = 1'b1;
		checking = 1'b0;
		m_lmpr   = '0;
		m_hmpr   = '0;
		m_ext_c  = '0;
		m_ext_d  = '0;
		m_beeper = 1'b0;
		m_lpt    = '0;
		m_strobe = 1'b0;
		m_vox_l  = '0;
		m_vox_r  = '0;
		repeat (3) @(negedge clk_sys);
		reset    = 1'b0;
		checking = 1'b1;

		// Reset state
		read_port(PORT_LMPR, value);
		check_value("lmpr", 32'(value), 32'(0));
		read_port(PORT_HMPR, value);
		check_value("hmpr", 32'(value), 32'(0));
		check_value("midi_tx", 32'(midi_tx), 32'(0));
		check_value("midi_int", 32'(midi_int), 32'(0));
		check_value("audio_l", 32'(audio_l), 32'(0));
		check_value("audio_r", 32'(audio_r), 32'(0));
		cpu_addr = 16'h0000;
		@(negedge clk_sys);
		check_value("rom_sel", 32'(rom_sel), 32'(1));

		// Random paging
		repeat (40) begin
			case (2'($urandom))
				2'd0:    port = PORT_LMPR;
				2'd1:    port = PORT_HMPR;
				2'd2:    port = PORT_EXT_C;
				default: port = PORT_EXT_D;
			endcase
			write_port(port, 8'($urandom));
			repeat (4) begin
				cpu_addr = 16'($urandom);
				@(negedge clk_sys);
			end
			read_port(PORT_LMPR, value);
			check_value("lmpr", 32'(value), 32'(m_lmpr));
			read_port(PORT_HMPR, value);
			check_value("hmpr", 32'(value), 32'(m_hmpr));
		end

		// Held io_wr writes once
		first    = 8'($urandom);
		second   = ~first;
		cpu_addr = {8'h00, PORT_LMPR};
		wr_data  = first;
		io_wr    = 1'b1;
		@(negedge clk_sys);
		update_model(PORT_LMPR, first);
		wr_data = second;
		@(negedge clk_sys);
		io_wr = 1'b0;
		@(negedge clk_sys);
		read_port(PORT_LMPR, value);
		check_value("lmpr", 32'(value), 32'(first));

		// MIDI single frame and then a second byte during the frame
		run_midi(1'b0, rises);
		check_value("midi_frames", 32'(rises), 32'(1));
		run_midi(1'b1, rises);
		check_value("midi_frames", 32'(rises), 32'(2));
		repeat ((MIDI_FRAME_TICKS + 10) * TICK_DIV) begin
			@(negedge clk_sys);
			check_value("midi_tx", 32'(midi_tx), 32'(0));
		end
		read_port(PORT_STATUS, value);
		check_value("status", 32'(value), 32'(8'hFF));

		// DAC strobe sequence and beeper
		first  = 8'($urandom);
		second = 8'($urandom);
		write_port(PORT_LPT_DATA, first);
		write_port(PORT_LPT_STROBE, 8'h01);
		write_port(PORT_LPT_DATA, second);
		write_port(PORT_LPT_STROBE, 8'h00);
		write_port(PORT_BORDER, 8'h10);
		check_value("audio_l", 32'(audio_l), 32'(mixed_sample(first, 1'b1)));
		check_value("audio_r", 32'(audio_r), 32'(mixed_sample(second, 1'b1)));

		$display("Verification passed");
		$finish;
	end

endmodule

// File: sam_asic_top.f
source/asic_pkg.sv
source/asic_port_decoder.sv
source/memory_pager.sv
source/midi_transmitter.sv
source/dac_mixer.sv
source/sam_asic_top.sv
sim/sam_asic_checker.sv
sim/sam_asic_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for the result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module sam_asic_tb \
	-f sam_asic_top.f \
	-o sam_asic_sim

# The simulator exits non-zero on a fatal check, the log decides the result
./obj_dir/sam_asic_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Verification passed" sim.log; then
	exit 0
else
	echo "Simulation did not pass, see sim.log"
	exit 1
fi
